// File: sources.f
+incdir+.
core_pkg.sv
apb_inst_port.sv
dispatch_unit.sv
reorder_buffer.sv
seq_multiplier.sv
arch_regfile.sv
ooo_core_top.sv
tb_ooo_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ooo_core
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: tb_ooo_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module tb_ooo_core;

   localparam int XLEN       = `CORE_XLEN;
   localparam int WAIT_LIMIT = 200;   // cycles per APB transfer
   localparam int IDLE_POLLS = 100;

   logic        clk;
   logic        reset;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [11:0] paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;

   logic [XLEN-1:0] model [`CORE_NREGS];   // program-order register state
   logic [31:0]     rng_state;
   int              checks;
   int              errors;
   int              tests;
   int              stalls;
   int              err_base;
   string           test_name;

   ooo_core_top dut_i (
      .clk     (clk),
      .reset   (reset),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic next_rand(output logic [31:0] r);
      rng_state = xorshift32(rng_state);
      r = rng_state;
   endtask

   // RV32I/M reference semantics
   function automatic logic [XLEN-1:0] ref_alu(input core_pkg::alu_op_e op,
                                               input logic [XLEN-1:0] a,
                                               input logic [XLEN-1:0] b);
      logic [4:0]        sh;
      logic [2*XLEN-1:0] prod;
      sh   = b[4:0];
      prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
      case (op)
         core_pkg::ADD:  return a + b;
         core_pkg::SUB:  return a - b;
         core_pkg::SLL:  return a << sh;
         core_pkg::SLT:  return {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
         core_pkg::SLTU: return {{(XLEN-1){1'b0}}, a < b};
         core_pkg::XOR:  return a ^ b;
         core_pkg::SRL:  return a >> sh;
         core_pkg::SRA:  return $signed(a) >>> sh;
         core_pkg::OR:   return a | b;
         core_pkg::AND:  return a & b;
         core_pkg::MUL:  return prod[XLEN-1:0];
         default:        return '0;
      endcase
   endfunction

   function automatic logic [2:0] funct3_of(input core_pkg::alu_op_e op);
      case (op)
         core_pkg::SLL:  return 3'd1;
         core_pkg::SLT:  return 3'd2;
         core_pkg::SLTU: return 3'd3;
         core_pkg::XOR:  return 3'd4;
         core_pkg::SRL:  return 3'd5;
         core_pkg::SRA:  return 3'd5;
         core_pkg::OR:   return 3'd6;
         core_pkg::AND:  return 3'd7;
         default:        return 3'd0;   // add, sub, mul
      endcase
   endfunction

   function automatic logic [6:0] funct7_of(input core_pkg::alu_op_e op);
      if (op == core_pkg::SUB || op == core_pkg::SRA)
         return 7'h20;
      if (op == core_pkg::MUL)
         return 7'h01;
      return 7'h00;
   endfunction

   task automatic abort_run(input string why);
      $display("timeout at %0t: %s", $time, why);
      $display("CHECKS FAILED");
      $finish;
   endtask

   task automatic report_fail(input string msg);
      errors++;
      $display("[FAIL] %0t: %s", $time, msg);
   endtask

   task automatic check_reg(input string what, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
      checks++;
      if (got !== exp)
         report_fail($sformatf("%s read %h, expected %h", what, got, exp));
   endtask

   task automatic check_error(input string what, input logic got, input logic exp);
      checks++;
      if (got !== exp)
         report_fail($sformatf("%s pslverr %b, expected %b", what, got, exp));
   endtask

   task automatic check_waits(input string what, input int got, input int exp);
      checks++;
      if (got != exp)
         report_fail($sformatf("%s took %0d wait states, expected %0d", what, got, exp));
   endtask

   // setup then access with outputs sampled at the falling edge
   task automatic apb_transfer(input logic wr, input logic [11:0] addr,
                               input logic [31:0] data, output logic [31:0] rdata,
                               output logic err, output int waits);
      int n;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = data;
      @(posedge clk);
      #2;
      penable = 1'b1;
      n = 0;
      @(negedge clk);
      while (!pready) begin
         n++;
         if (n > WAIT_LIMIT)
            abort_run($sformatf("pready never rose for address %h", addr));
         @(negedge clk);
      end
      rdata = prdata;
      err   = pslverr;
      waits = n;
      @(posedge clk);
      #2;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                            output logic err);
      logic [31:0] unused_rd;
      int          waits;
      apb_transfer(1'b1, addr, data, unused_rd, err, waits);
      if (waits > 0)
         stalls++;
   endtask

   task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
      logic err;
      int   waits;
      apb_transfer(1'b0, addr, 32'd0, data, err, waits);
      check_error($sformatf("read %h", addr), err, 1'b0);
      check_waits($sformatf("read %h", addr), waits, 0);   // pready in first access cycle
   endtask

   task automatic wait_idle();
      logic [31:0] st;
      int          polls;
      polls = 0;
      apb_read(`CORE_ADDR_STATUS, st);
      while (!st[0]) begin
         polls++;
         if (polls > IDLE_POLLS)
            abort_run("reorder buffer never drained");
         apb_read(`CORE_ADDR_STATUS, st);
      end
   endtask

   task automatic compare_model();
      logic [31:0] val;
      for (int r = 0; r < `CORE_NREGS; r++) begin
         apb_read(`CORE_ADDR_REG_BASE + 12'(4 * r), val);
         check_reg($sformatf("x%0d", r), val, model[r]);
      end
   endtask

   task automatic issue_r(input core_pkg::alu_op_e op, input logic [4:0] rd,
                          input logic [4:0] rs1, input logic [4:0] rs2);
      logic err;
      apb_write(`CORE_ADDR_INST,
                {funct7_of(op), rs2, rs1, funct3_of(op), rd, core_pkg::OP}, err);
      check_error($sformatf("%s x%0d", op.name(), rd), err, 1'b0);
      if (rd != 5'd0)
         model[rd] = ref_alu(op, model[rs1], model[rs2]);
   endtask

   task automatic issue_i(input core_pkg::alu_op_e op, input logic [4:0] rd,
                          input logic [4:0] rs1, input logic [11:0] imm);
      logic        err;
      logic [11:0] field;
      field = imm;
      if (op == core_pkg::SLL || op == core_pkg::SRL || op == core_pkg::SRA)
         field = {funct7_of(op), imm[4:0]};   // shamt form
      apb_write(`CORE_ADDR_INST,
                {field, rs1, funct3_of(op), rd, core_pkg::OP_IMM}, err);
      check_error($sformatf("%s imm x%0d", op.name(), rd), err, 1'b0);
      if (rd != 5'd0)
         model[rd] = ref_alu(op, model[rs1], {{(XLEN-12){field[11]}}, field});
   endtask

   task automatic start_test(input string name);
      test_name = name;
      err_base  = errors;
      tests++;
   endtask

   task automatic end_test();
      if (errors == err_base)
         $display("test %0d %s: ok", tests, test_name);
      else
         $display("test %0d %s: %0d errors", tests, test_name, errors - err_base);
   endtask

   task automatic test_reset_state();
      logic [31:0] st;
      start_test("reset state");
      apb_read(`CORE_ADDR_STATUS, st);
      check_reg("status", st, 32'h1);
      compare_model();
      end_test();
   endtask

   task automatic test_alu_ops();
      start_test("alu ops");
      issue_i(core_pkg::ADD, 5'd1, 5'd0, 12'h7ab);
      issue_i(core_pkg::SLL, 5'd1, 5'd1, 12'd20);
      issue_i(core_pkg::XOR, 5'd1, 5'd1, 12'h9c3);   // negative
      issue_i(core_pkg::ADD, 5'd2, 5'd0, 12'hffb);   // -5
      for (int k = 0; k < 11; k++)
         issue_r(core_pkg::alu_op_e'(k), 5'(3 + k), 5'd1, 5'd2);
      issue_i(core_pkg::ADD, 5'd14, 5'd1, 12'h800);
      issue_i(core_pkg::SLT, 5'd15, 5'd1, 12'h005);
      issue_i(core_pkg::SLTU, 5'd16, 5'd0, 12'hfff);
      issue_i(core_pkg::XOR, 5'd17, 5'd1, 12'h5a5);
      issue_i(core_pkg::OR, 5'd18, 5'd2, 12'h3c0);
      issue_i(core_pkg::AND, 5'd19, 5'd1, 12'hf0f);
      issue_i(core_pkg::SLL, 5'd20, 5'd2, 12'd7);
      issue_i(core_pkg::SRL, 5'd21, 5'd1, 12'd13);
      issue_i(core_pkg::SRA, 5'd22, 5'd1, 12'd9);
      issue_r(core_pkg::ADD, 5'd0, 5'd1, 5'd2);   // x0 stays zero
      wait_idle();
      compare_model();
      end_test();
   endtask

   task automatic test_dep_chain();
      start_test("dependency chain");
      issue_i(core_pkg::ADD, 5'd5, 5'd0, 12'd7);
      issue_r(core_pkg::ADD, 5'd6, 5'd5, 5'd5);
      issue_r(core_pkg::SUB, 5'd7, 5'd6, 5'd1);
      issue_r(core_pkg::XOR, 5'd8, 5'd7, 5'd6);
      issue_i(core_pkg::SLL, 5'd9, 5'd8, 12'd3);
      issue_r(core_pkg::OR, 5'd10, 5'd9, 5'd5);
      issue_r(core_pkg::SLT, 5'd5, 5'd10, 5'd9);
      issue_r(core_pkg::ADD, 5'd6, 5'd5, 5'd10);
      wait_idle();
      compare_model();
      end_test();
   endtask

   task automatic test_mul_waw();
      start_test("multiply and waw");
      issue_r(core_pkg::MUL, 5'd11, 5'd1, 5'd2);
      issue_r(core_pkg::ADD, 5'd15, 5'd11, 5'd5);   // consumes the product
      issue_i(core_pkg::ADD, 5'd12, 5'd0, 12'd5);
      issue_r(core_pkg::ADD, 5'd13, 5'd12, 5'd12);
      issue_i(core_pkg::ADD, 5'd11, 5'd0, 12'd99);  // younger writer of x11
      issue_r(core_pkg::MUL, 5'd16, 5'd13, 5'd7);
      wait_idle();
      compare_model();
      end_test();
   endtask

   task automatic test_burst();
      int stall_base;
      start_test("buffer full burst");
      stall_base = stalls;
      issue_r(core_pkg::MUL, 5'd17, 5'd1, 5'd1);    // holds the head for a while
      for (int k = 0; k < 11; k++)
         issue_i(core_pkg::ADD, 5'(18 + k % 6), 5'(17 + k % 6), 12'(k + 1));
      if (stalls == stall_base)
         report_fail("no instruction write was stalled by a full buffer");
      wait_idle();
      compare_model();
      end_test();
   endtask

   task automatic test_illegal_random();
      logic               err;
      logic [31:0]        r;
      core_pkg::alu_op_e  op;
      start_test("illegal and random");
      apb_write(`CORE_ADDR_INST, 32'h0000_2083, err);   // load opcode
      check_error("load opcode", err, 1'b1);
      apb_write(`CORE_ADDR_INST, 32'h4000_10b3, err);   // sll with bad funct7
      check_error("bad funct7", err, 1'b1);
      apb_write(`CORE_ADDR_INST, 32'hffff_ffff, err);
      check_error("all ones", err, 1'b1);
      wait_idle();
      compare_model();
      for (int k = 0; k < 40; k++) begin
         next_rand(r);
         op = core_pkg::alu_op_e'(4'(r[3:0] % 4'd11));
         if (r[31] && op != core_pkg::SUB && op != core_pkg::MUL)
            issue_i(op, r[8:4], r[13:9], r[30:19]);
         else
            issue_r(op, r[8:4], r[13:9], r[18:14]);
      end
      wait_idle();
      compare_model();
      end_test();
   endtask

   initial begin
      rng_state = 32'hf898_56a4;
      checks    = 0;
      errors    = 0;
      tests     = 0;
      stalls    = 0;
      for (int r = 0; r < `CORE_NREGS; r++)
         model[r] = '0;
      reset   = 1'b1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      repeat (5) @(posedge clk);
      #2;
      reset = 1'b0;

      test_reset_state();
      test_alu_ops();
      test_dep_chain();
      test_mul_waw();
      test_burst();
      test_illegal_random();

      $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: ooo_core_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module ooo_core_top (
   input  wire logic        clk,
   input  wire logic        reset,
   input  wire logic        psel,
   input  wire logic        penable,
   input  wire logic        pwrite,
   input  wire logic [11:0] paddr,
   input  wire logic [31:0] pwdata,
   output logic      [31:0] prdata,
   output logic             pready,
   output logic             pslverr
);

   // APB port to dispatch
   logic        inst_valid, dispatch_ready, inst_illegal, rob_empty;
   logic [31:0] inst;

   // register file reads
   logic [4:0]            host_reg_addr, rs1_addr, rs2_addr;
   logic [`CORE_XLEN-1:0] host_reg_data, rs1_data, rs2_data;

   // allocation and rename lookup
   logic                  alloc_valid, rob_full;
   core_pkg::alu_op_e     alloc_op;
   logic [4:0]            alloc_dest;
   logic                  src_a_ready, src_b_ready, lookup_done_a, lookup_done_b;
   logic [`CORE_XLEN-1:0] src_a_value, src_b_value, lookup_value_a, lookup_value_b;
   core_pkg::rob_tag_t    src_a_tag, src_b_tag, alloc_tag, lookup_tag_a, lookup_tag_b;

   // multiplier
   logic                  mul_start, mul_busy, mul_done;
   logic [`CORE_XLEN-1:0] mul_a, mul_b, mul_result;
   core_pkg::rob_tag_t    mul_tag_in, mul_tag_out;

   // commit
   logic                  commit_valid;
   logic [4:0]            commit_dest;
   logic [`CORE_XLEN-1:0] commit_value;
   core_pkg::rob_tag_t    commit_tag;

   apb_inst_port  u_apb_inst_port  (.*);
   dispatch_unit  u_dispatch_unit  (.*);
   reorder_buffer u_reorder_buffer (.*);
   seq_multiplier u_seq_multiplier (.*);
   arch_regfile   u_arch_regfile   (.*);

endmodule

`default_nettype wire

// File: arch_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module arch_regfile (
   input  wire logic                  clk,
   input  wire logic                  reset,
   input  wire logic                  commit_valid,
   input  wire logic [4:0]            commit_dest,
   input  wire logic [`CORE_XLEN-1:0] commit_value,
   input  wire logic [4:0]            rs1_addr,
   input  wire logic [4:0]            rs2_addr,
   output logic      [`CORE_XLEN-1:0] rs1_data,
   output logic      [`CORE_XLEN-1:0] rs2_data,
   input  wire logic [4:0]            host_reg_addr,
   output logic      [`CORE_XLEN-1:0] host_reg_data
);

   logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

   // only in-order commit writes here, x0 stays zero
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `CORE_NREGS; i++)
            regs[i] <= '0;
      end else if (commit_valid && commit_dest != 5'd0) begin
         regs[commit_dest] <= commit_value;
      end
   end

   assign rs1_data      = regs[rs1_addr];
   assign rs2_data      = regs[rs2_addr];
   assign host_reg_data = regs[host_reg_addr];

endmodule

`default_nettype wire

// File: seq_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module seq_multiplier (
   input  wire logic                  clk,
   input  wire logic                  reset,
   input  wire logic                  mul_start,
   input  wire logic [`CORE_XLEN-1:0] mul_a,
   input  wire logic [`CORE_XLEN-1:0] mul_b,
   input  wire core_pkg::rob_tag_t    mul_tag_in,
   output logic                       mul_busy,
   output logic                       mul_done,
   output logic      [`CORE_XLEN-1:0] mul_result,
   output core_pkg::rob_tag_t         mul_tag_out
);

   localparam int XLEN = `CORE_XLEN;
   localparam int SW   = $clog2(XLEN);

   typedef enum logic [1:0] {IDLE, RUN, DONE} state_e;

   state_e             state;
   logic [SW-1:0]      step;
   logic [XLEN-1:0]    mcand, mplier, acc;
   core_pkg::rob_tag_t tag;

   assign mul_busy    = (state != IDLE);
   assign mul_done    = (state == DONE);   // one cycle pulse
   assign mul_result  = acc;
   assign mul_tag_out = tag;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= IDLE;
         step  <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (mul_start) begin
                  state  <= RUN;
                  step   <= '0;
                  acc    <= '0;
                  mcand  <= mul_a;
                  mplier <= mul_b;
                  tag    <= mul_tag_in;
               end
            end
            RUN: begin   // one multiplier bit per cycle
               if (mplier[0])
                  acc <= acc + mcand;
               mcand  <= mcand << 1;
               mplier <= mplier >> 1;
               step   <= step + 1'b1;
               if (step == SW'(XLEN - 1))
                  state <= DONE;
            end
            default: state <= IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module reorder_buffer (
   input  wire logic                  clk,
   input  wire logic                  reset,
   input  wire logic                  alloc_valid,
   input  wire core_pkg::alu_op_e     alloc_op,
   input  wire logic [4:0]            alloc_dest,
   input  wire logic                  src_a_ready,
   input  wire logic [`CORE_XLEN-1:0] src_a_value,
   input  wire core_pkg::rob_tag_t    src_a_tag,
   input  wire logic                  src_b_ready,
   input  wire logic [`CORE_XLEN-1:0] src_b_value,
   input  wire core_pkg::rob_tag_t    src_b_tag,
   output core_pkg::rob_tag_t         alloc_tag,
   output logic                       rob_full,
   output logic                       rob_empty,
   input  wire core_pkg::rob_tag_t    lookup_tag_a,
   input  wire core_pkg::rob_tag_t    lookup_tag_b,
   output logic                       lookup_done_a,
   output logic                       lookup_done_b,
   output logic      [`CORE_XLEN-1:0] lookup_value_a,
   output logic      [`CORE_XLEN-1:0] lookup_value_b,
   output logic                       mul_start,
   output logic      [`CORE_XLEN-1:0] mul_a,
   output logic      [`CORE_XLEN-1:0] mul_b,
   output core_pkg::rob_tag_t         mul_tag_in,
   input  wire logic                  mul_busy,
   input  wire logic                  mul_done,
   input  wire logic [`CORE_XLEN-1:0] mul_result,
   input  wire core_pkg::rob_tag_t    mul_tag_out,
   output logic                       commit_valid,
   output logic      [4:0]            commit_dest,
   output logic      [`CORE_XLEN-1:0] commit_value,
   output core_pkg::rob_tag_t         commit_tag
);

   localparam int XLEN  = `CORE_XLEN;
   localparam int DEPTH = `CORE_ROB_DEPTH;
   localparam int CW    = $clog2(DEPTH) + 1;

   // entry state
   logic [DEPTH-1:0]   valid, issued, done, a_rdy, b_rdy;
   core_pkg::alu_op_e  op     [DEPTH];
   logic [4:0]         dest   [DEPTH];
   logic [XLEN-1:0]    a_val  [DEPTH];
   logic [XLEN-1:0]    b_val  [DEPTH];
   logic [XLEN-1:0]    result [DEPTH];
   core_pkg::rob_tag_t a_tag  [DEPTH];
   core_pkg::rob_tag_t b_tag  [DEPTH];

   core_pkg::rob_tag_t head, tail, idx;
   logic [CW-1:0]      count;

   // ALU execute stage
   logic               alu_valid;
   core_pkg::rob_tag_t alu_tag;
   core_pkg::alu_op_e  alu_op;
   logic [XLEN-1:0]    alu_a, alu_b, alu_result;

   logic               alu_pick, mul_pick;
   core_pkg::rob_tag_t alu_sel, mul_sel;

   function automatic logic [XLEN-1:0] alu_eval(input core_pkg::alu_op_e f,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
      logic [$clog2(XLEN)-1:0] sh;
      sh = b[$clog2(XLEN)-1:0];
      case (f)
         core_pkg::ADD:  return a + b;
         core_pkg::SUB:  return a - b;
         core_pkg::SLL:  return a << sh;
         core_pkg::SLT:  return XLEN'($signed(a) < $signed(b));
         core_pkg::SLTU: return XLEN'(a < b);
         core_pkg::XOR:  return a ^ b;
         core_pkg::SRL:  return a >> sh;
         core_pkg::SRA:  return $signed(a) >>> sh;
         core_pkg::OR:   return a | b;
         core_pkg::AND:  return a & b;
         default:        return '0;   // MUL never reaches here
      endcase
   endfunction

   assign alu_result = alu_eval(alu_op, alu_a, alu_b);

   assign alloc_tag = tail;
   assign rob_full  = (count == CW'(DEPTH));
   assign rob_empty = (count == '0);

   // lookups see this cycle's completions too
   always_comb begin
      lookup_done_a  = done[lookup_tag_a];
      lookup_value_a = result[lookup_tag_a];
      lookup_done_b  = done[lookup_tag_b];
      lookup_value_b = result[lookup_tag_b];
      if (alu_valid && alu_tag == lookup_tag_a) begin
         lookup_done_a  = 1'b1;
         lookup_value_a = alu_result;
      end else if (mul_done && mul_tag_out == lookup_tag_a) begin
         lookup_done_a  = 1'b1;
         lookup_value_a = mul_result;
      end
      if (alu_valid && alu_tag == lookup_tag_b) begin
         lookup_done_b  = 1'b1;
         lookup_value_b = alu_result;
      end else if (mul_done && mul_tag_out == lookup_tag_b) begin
         lookup_done_b  = 1'b1;
         lookup_value_b = mul_result;
      end
   end

   // oldest ready entry per unit, scanning from head
   always_comb begin
      alu_pick = 1'b0;
      alu_sel  = head;
      mul_pick = 1'b0;
      mul_sel  = head;
      idx      = head;
      for (int i = 0; i < DEPTH; i++) begin
         idx = head + core_pkg::rob_tag_t'(i);
         if (valid[idx] && !issued[idx] && a_rdy[idx] && b_rdy[idx]) begin
            if (op[idx] == core_pkg::MUL) begin
               if (!mul_pick) begin
                  mul_pick = 1'b1;
                  mul_sel  = idx;
               end
            end else if (!alu_pick) begin
               alu_pick = 1'b1;
               alu_sel  = idx;
            end
         end
      end
   end

   assign mul_start  = mul_pick && !mul_busy;
   assign mul_a      = a_val[mul_sel];
   assign mul_b      = b_val[mul_sel];
   assign mul_tag_in = mul_sel;

   assign commit_valid = valid[head] && done[head];
   assign commit_dest  = dest[head];
   assign commit_value = result[head];
   assign commit_tag   = head;

   always_ff @(posedge clk) begin
      if (reset) begin
         valid     <= '0;
         issued    <= '0;
         done      <= '0;
         head      <= '0;
         tail      <= '0;
         count     <= '0;
         alu_valid <= 1'b0;
      end else begin
         alu_valid <= alu_pick;
         if (alu_pick) begin
            issued[alu_sel] <= 1'b1;
            alu_tag         <= alu_sel;
            alu_op          <= op[alu_sel];
            alu_a           <= a_val[alu_sel];
            alu_b           <= b_val[alu_sel];
         end
         if (mul_start)
            issued[mul_sel] <= 1'b1;

         // writeback and wakeup
         if (alu_valid) begin
            done[alu_tag]   <= 1'b1;
            result[alu_tag] <= alu_result;
         end
         if (mul_done) begin
            done[mul_tag_out]   <= 1'b1;
            result[mul_tag_out] <= mul_result;
         end
         for (int i = 0; i < DEPTH; i++) begin
            if (!a_rdy[i] && alu_valid && a_tag[i] == alu_tag) begin
               a_rdy[i] <= 1'b1;
               a_val[i] <= alu_result;
            end else if (!a_rdy[i] && mul_done && a_tag[i] == mul_tag_out) begin
               a_rdy[i] <= 1'b1;
               a_val[i] <= mul_result;
            end
            if (!b_rdy[i] && alu_valid && b_tag[i] == alu_tag) begin
               b_rdy[i] <= 1'b1;
               b_val[i] <= alu_result;
            end else if (!b_rdy[i] && mul_done && b_tag[i] == mul_tag_out) begin
               b_rdy[i] <= 1'b1;
               b_val[i] <= mul_result;
            end
         end

         if (commit_valid) begin
            valid[head] <= 1'b0;
            head        <= head + 1'b1;
         end
         if (alloc_valid) begin   // tail slot is free, overrides wakeup
            valid[tail]  <= 1'b1;
            issued[tail] <= 1'b0;
            done[tail]   <= 1'b0;
            op[tail]     <= alloc_op;
            dest[tail]   <= alloc_dest;
            a_rdy[tail]  <= src_a_ready;
            a_val[tail]  <= src_a_value;
            a_tag[tail]  <= src_a_tag;
            b_rdy[tail]  <= src_b_ready;
            b_val[tail]  <= src_b_value;
            b_tag[tail]  <= src_b_tag;
            tail         <= tail + 1'b1;
         end
         count <= count + CW'(alloc_valid) - CW'(commit_valid);
      end
   end

endmodule

`default_nettype wire

// File: dispatch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module dispatch_unit (
   input  wire logic                  clk,
   input  wire logic                  reset,
   input  wire logic                  inst_valid,
   input  wire logic [31:0]           inst,
   output logic                       dispatch_ready,
   output logic                       inst_illegal,
   output logic      [4:0]            rs1_addr,
   output logic      [4:0]            rs2_addr,
   input  wire logic [`CORE_XLEN-1:0] rs1_data,
   input  wire logic [`CORE_XLEN-1:0] rs2_data,
   output logic                       alloc_valid,
   output core_pkg::alu_op_e          alloc_op,
   output logic      [4:0]            alloc_dest,
   output logic                       src_a_ready,
   output logic      [`CORE_XLEN-1:0] src_a_value,
   output core_pkg::rob_tag_t         src_a_tag,
   output logic                       src_b_ready,
   output logic      [`CORE_XLEN-1:0] src_b_value,
   output core_pkg::rob_tag_t         src_b_tag,
   input  wire core_pkg::rob_tag_t    alloc_tag,
   input  wire logic                  rob_full,
   output core_pkg::rob_tag_t         lookup_tag_a,
   output core_pkg::rob_tag_t         lookup_tag_b,
   input  wire logic                  lookup_done_a,
   input  wire logic                  lookup_done_b,
   input  wire logic [`CORE_XLEN-1:0] lookup_value_a,
   input  wire logic [`CORE_XLEN-1:0] lookup_value_b,
   input  wire logic                  commit_valid,
   input  wire logic [4:0]            commit_dest,
   input  wire core_pkg::rob_tag_t    commit_tag
);

   localparam int XLEN = `CORE_XLEN;

   logic [6:0] funct7;
   logic [2:0] funct3;
   logic use_imm;
   logic [XLEN-1:0] imm;

   // register status table, busy means a ROB entry will write it
   logic [`CORE_NREGS-1:0] stat_busy;
   core_pkg::rob_tag_t     stat_tag [`CORE_NREGS];

   // {ready, value} from the register file or a finished ROB entry
   function automatic logic [XLEN:0] resolve(input logic busy, input logic done,
                                             input logic [XLEN-1:0] rf_val,
                                             input logic [XLEN-1:0] rob_val);
      if (!busy)
         return {1'b1, rf_val};
      if (done)
         return {1'b1, rob_val};
      return '0;
   endfunction

   assign funct7     = inst[31:25];
   assign funct3     = inst[14:12];
   assign rs1_addr   = inst[19:15];
   assign rs2_addr   = inst[24:20];
   assign alloc_dest = inst[11:7];
   assign imm        = {{(XLEN-12){inst[31]}}, inst[31:20]};

   always_comb begin
      inst_illegal = 1'b0;
      use_imm      = 1'b0;
      alloc_op     = core_pkg::ADD;
      case (inst[6:0])
         core_pkg::OP: begin
            case ({funct7, funct3})
               {7'h00, 3'd0}: alloc_op = core_pkg::ADD;
               {7'h20, 3'd0}: alloc_op = core_pkg::SUB;
               {7'h00, 3'd1}: alloc_op = core_pkg::SLL;
               {7'h00, 3'd2}: alloc_op = core_pkg::SLT;
               {7'h00, 3'd3}: alloc_op = core_pkg::SLTU;
               {7'h00, 3'd4}: alloc_op = core_pkg::XOR;
               {7'h00, 3'd5}: alloc_op = core_pkg::SRL;
               {7'h20, 3'd5}: alloc_op = core_pkg::SRA;
               {7'h00, 3'd6}: alloc_op = core_pkg::OR;
               {7'h00, 3'd7}: alloc_op = core_pkg::AND;
               {7'h01, 3'd0}: alloc_op = core_pkg::MUL;   // M extension
               default:       inst_illegal = 1'b1;
            endcase
         end
         core_pkg::OP_IMM: begin
            use_imm = 1'b1;
            case (funct3)
               3'd0: alloc_op = core_pkg::ADD;
               3'd2: alloc_op = core_pkg::SLT;
               3'd3: alloc_op = core_pkg::SLTU;
               3'd4: alloc_op = core_pkg::XOR;
               3'd6: alloc_op = core_pkg::OR;
               3'd7: alloc_op = core_pkg::AND;
               3'd1: begin
                  alloc_op     = core_pkg::SLL;
                  inst_illegal = (funct7 != 7'h00);
               end
               default: begin   // 3'd5, srli or srai
                  alloc_op     = (funct7 == 7'h20) ? core_pkg::SRA : core_pkg::SRL;
                  inst_illegal = (funct7 != 7'h00) && (funct7 != 7'h20);
               end
            endcase
         end
         default: inst_illegal = 1'b1;
      endcase
   end

   assign dispatch_ready = !rob_full;
   assign alloc_valid    = inst_valid && !rob_full;

   // rename
   assign lookup_tag_a = stat_tag[rs1_addr];
   assign lookup_tag_b = stat_tag[rs2_addr];
   assign src_a_tag    = lookup_tag_a;
   assign src_b_tag    = lookup_tag_b;
   assign {src_a_ready, src_a_value} =
      resolve(stat_busy[rs1_addr], lookup_done_a, rs1_data, lookup_value_a);
   assign {src_b_ready, src_b_value} = use_imm ? {1'b1, imm} :
      resolve(stat_busy[rs2_addr], lookup_done_b, rs2_data, lookup_value_b);

   always_ff @(posedge clk) begin
      if (reset) begin
         stat_busy <= '0;
      end else begin
         // a younger writer may already own the register
         if (commit_valid && stat_busy[commit_dest] && stat_tag[commit_dest] == commit_tag)
            stat_busy[commit_dest] <= 1'b0;
         if (alloc_valid && alloc_dest != 5'd0) begin   // x0 never busy
            stat_busy[alloc_dest] <= 1'b1;
            stat_tag[alloc_dest]  <= alloc_tag;
         end
      end
   end

endmodule

`default_nettype wire

// File: apb_inst_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module apb_inst_port (
   input  wire logic                  clk,
   input  wire logic                  reset,
   input  wire logic                  psel,
   input  wire logic                  penable,
   input  wire logic                  pwrite,
   input  wire logic [11:0]           paddr,
   input  wire logic [31:0]           pwdata,
   output logic      [31:0]           prdata,
   output logic                       pready,
   output logic                       pslverr,
   output logic                       inst_valid,
   output logic      [31:0]           inst,
   input  wire logic                  dispatch_ready,
   input  wire logic                  inst_illegal,
   input  wire logic                  rob_empty,
   output logic      [4:0]            host_reg_addr,
   input  wire logic [`CORE_XLEN-1:0] host_reg_data
);

   logic setup;
   logic access;
   logic inst_wr;
   logic reg_hit;
   logic [11:0] reg_off;

   assign setup   = psel && !penable;
   assign access  = psel && penable;
   assign inst_wr = access && pwrite && (paddr == `CORE_ADDR_INST);

   assign inst       = pwdata;
   assign inst_valid = inst_wr && !inst_illegal;
   assign pslverr    = inst_wr && inst_illegal;   // rejected, nothing dispatched
   // only instruction writes can stall
   assign pready     = access && (!inst_wr || dispatch_ready || inst_illegal);

   assign reg_off       = paddr - `CORE_ADDR_REG_BASE;
   assign host_reg_addr = reg_off[6:2];
   assign reg_hit       = (paddr >= `CORE_ADDR_REG_BASE) &&
                          (paddr < `CORE_ADDR_REG_BASE + 12'(4 * `CORE_NREGS));

   // read data captured in setup so it is ready in the first access cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         prdata <= '0;
      end else if (setup && !pwrite) begin
         if (paddr == `CORE_ADDR_STATUS)
            prdata <= {31'd0, rob_empty};   // bit 0 idle
         else if (reg_hit)
            prdata <= host_reg_data;
         else
            prdata <= '0;
      end
   end

endmodule

`default_nettype wire

// File: core_pkg.sv
`default_nettype none

`include "core_settings.svh"

package core_pkg;

   // major opcodes handled by the core, all others are illegal
   typedef enum logic [6:0] {
      OP     = 7'b0110011,
      OP_IMM = 7'b0010011
   } opcode_e;

   typedef enum logic [3:0] {
      ADD  = 4'd0,
      SUB  = 4'd1,
      SLL  = 4'd2,
      SLT  = 4'd3,
      SLTU = 4'd4,
      XOR  = 4'd5,
      SRL  = 4'd6,
      SRA  = 4'd7,
      OR   = 4'd8,
      AND  = 4'd9,
      MUL  = 4'd10   // low half of product
   } alu_op_e;

   // reorder buffer slot, also the rename tag
   typedef logic [$clog2(`CORE_ROB_DEPTH)-1:0] rob_tag_t;

endpackage

`default_nettype wire

// File: core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// datapath and architectural state
`define CORE_XLEN      32
`define CORE_NREGS     32

// reorder buffer entries, power of two
`define CORE_ROB_DEPTH 8

// APB address map (12-bit paddr)
`define CORE_ADDR_INST     12'h000
`define CORE_ADDR_STATUS   12'h004
`define CORE_ADDR_REG_BASE 12'h100

`endif
